// File: rtl/cmac_pkg.sv
// cmac package
// sizes, pipeline latencies, stripe-info fields, register map and the
// packed bus types shared by the convolution MAC core
package cmac_pkg;

  // ==========================================================================
  // sizes
  // ==========================================================================
  localparam int CMAC_ATOMC          = 8;
  localparam int CMAC_ATOMK_HALF     = 4;
  localparam int CMAC_BYTE_WIDTH     = 8;
  // signed 8x8 product
  localparam int CMAC_PROD_WIDTH     = 16;
  // product width plus log2(ATOMC) bits of adder-tree growth
  localparam int CMAC_RESULT_WIDTH   = 19;
  localparam int CMAC_PD_WIDTH       = 9;
  localparam int CMAC_KIDX_WIDTH     = $clog2(CMAC_ATOMK_HALF);
  localparam int CMAC_DONE_CNT_WIDTH = 16;
  localparam int APB_ADDR_WIDTH      = 12;
  localparam int APB_DATA_WIDTH      = 32;

  // pipeline latencies in core clock cycles
  localparam int CMAC_IN_RT_LATENCY  = 2;
  localparam int CMAC_MAC_LATENCY    = 2;
  localparam int CMAC_OUT_RT_LATENCY = 2;

  // stripe-info word, bits 5:0 are a tag carried through untouched
  localparam int PKT_STRIPE_ST_FIELD  = 6;
  localparam int PKT_STRIPE_END_FIELD = 7;
  localparam int PKT_LAYER_END_FIELD  = 8;

  // ==========================================================================
  // vector types
  // ==========================================================================
  typedef logic signed [CMAC_BYTE_WIDTH-1:0]   cmac_byte_t;
  typedef logic signed [CMAC_PROD_WIDTH-1:0]   cmac_prod_t;
  typedef logic signed [CMAC_RESULT_WIDTH-1:0] cmac_result_t;
  typedef logic [CMAC_ATOMK_HALF-1:0]          cmac_mask_t;
  typedef logic [CMAC_PD_WIDTH-1:0]            cmac_pd_t;
  typedef logic [CMAC_KIDX_WIDTH-1:0]          cmac_kidx_t;
  typedef logic [APB_ADDR_WIDTH-1:0]           apb_addr_t;
  typedef logic [APB_DATA_WIDTH-1:0]           apb_data_t;

  // register map
  localparam apb_addr_t REG_OP_EN_ADDR     = 12'h000;
  localparam apb_addr_t REG_KERNEL_EN_ADDR = 12'h004;
  localparam apb_addr_t REG_DONE_CNT_ADDR  = 12'h008;

  // ==========================================================================
  // packed bundles
  // ==========================================================================
  // activation packet
  typedef struct packed {
    logic                         valid;
    cmac_pd_t                     pd;
    cmac_byte_t [CMAC_ATOMC-1:0]  data;
  } cmac_dat_t;

  // weight-load atom for one kernel
  typedef struct packed {
    logic                         valid;
    cmac_kidx_t                   kidx;
    cmac_byte_t [CMAC_ATOMC-1:0]  data;
  } cmac_wt_t;

  // partial sums towards the accumulator
  typedef struct packed {
    logic                              valid;
    cmac_mask_t                        mask;
    cmac_pd_t                          pd;
    cmac_result_t [CMAC_ATOMK_HALF-1:0] data;
  } cmac_out_t;

  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

endpackage

// File: rtl/cmac_cfg_regs.sv
// cmac configuration registers
// APB slave with the operation enable, the kernel enable mask and a
// read-only count of layer-done pulses
module cmac_cfg_regs
  import cmac_pkg::*;
(
  input  logic       nvdla_core_clk,
  input  logic       reset,
  input  apb_req_t   apb_req,
  output apb_rsp_t   apb_rsp,
  input  logic       dp2reg_done,
  output logic       op_en,
  output cmac_mask_t kernel_en
);

  // bus phase tracker
  typedef enum logic [1:0] {
    APB_IDLE,
    APB_SETUP,
    APB_ACCESS
  } apb_state_e;

  apb_state_e                     state;
  apb_state_e                     state_nxt;
  logic                           access_cyc;
  logic                           addr_hit;
  logic                           wr_en;
  apb_data_t                      rd_data;
  logic [CMAC_DONE_CNT_WIDTH-1:0] done_cnt;

  // ==========================================================================
  // APB phase FSM
  // ==========================================================================
  always_comb begin
    state_nxt = APB_IDLE;
    if (apb_req.psel && !apb_req.penable) begin
      state_nxt = APB_SETUP;
    end else if (apb_req.psel && apb_req.penable && state == APB_SETUP) begin
      state_nxt = APB_ACCESS;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (reset) begin
      state <= APB_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // access cycle only right after a setup cycle
  assign access_cyc = (state == APB_SETUP) & apb_req.psel & apb_req.penable;

  // address decode and read mux
  always_comb begin
    addr_hit = 1'b1;
    rd_data  = '0;
    case (apb_req.paddr)
      REG_OP_EN_ADDR:     rd_data[0] = op_en;
      REG_KERNEL_EN_ADDR: rd_data[CMAC_ATOMK_HALF-1:0] = kernel_en;
      REG_DONE_CNT_ADDR:  rd_data[CMAC_DONE_CNT_WIDTH-1:0] = done_cnt;
      default:            addr_hit = 1'b0;
    endcase
  end

  assign wr_en = access_cyc & apb_req.pwrite & addr_hit;

  // no wait states, error only on an unmapped access
  always_comb begin
    apb_rsp.prdata  = (access_cyc && !apb_req.pwrite) ? rd_data : '0;
    apb_rsp.pready  = 1'b1;
    apb_rsp.pslverr = access_cyc & ~addr_hit;
  end

  // ==========================================================================
  // register state
  // ==========================================================================
  always_ff @(posedge nvdla_core_clk) begin
    if (reset) begin
      op_en     <= 1'b0;
      kernel_en <= '0;
      done_cnt  <= '0;
    end else begin
      // layer done ends the operation
      if (dp2reg_done) begin
        op_en <= 1'b0;
      end else if (wr_en && apb_req.paddr == REG_OP_EN_ADDR) begin
        op_en <= apb_req.pwdata[0];
      end
      if (wr_en && apb_req.paddr == REG_KERNEL_EN_ADDR) begin
        kernel_en <= apb_req.pwdata[CMAC_ATOMK_HALF-1:0];
      end
      // done count is read only, writes to it fall through
      if (dp2reg_done) begin
        done_cnt <= done_cnt + 1'b1;
      end
    end
  end

endmodule

// File: rtl/cmac_in_rt.sv
// cmac input retiming
// delays activation and weight-load packets by CMAC_IN_RT_LATENCY stages,
// activations are dropped at the first stage while op enable is low
module cmac_in_rt
  import cmac_pkg::*;
(
  input  logic      nvdla_core_clk,
  input  logic      reset,
  input  logic      op_en,
  input  cmac_dat_t dat_in,
  input  cmac_wt_t  wt_in,
  output cmac_dat_t dat_rt,
  output cmac_wt_t  wt_rt
);

  cmac_dat_t dat_gated;
  cmac_dat_t dat_pipe [CMAC_IN_RT_LATENCY];
  cmac_wt_t  wt_pipe  [CMAC_IN_RT_LATENCY];

  // drop activations when the core is not enabled
  always_comb begin
    dat_gated       = dat_in;
    dat_gated.valid = dat_in.valid & op_en;
  end

  // ==========================================================================
  // retiming stages
  // ==========================================================================
  for (genvar i = 0; i < CMAC_IN_RT_LATENCY; i++) begin : g_stage
    cmac_dat_t dat_d;
    cmac_wt_t  wt_d;

    // stage input, either the port or the previous stage
    if (i == 0) begin : g_head
      assign dat_d = dat_gated;
      assign wt_d  = wt_in;
    end else begin : g_body
      assign dat_d = dat_pipe[i-1];
      assign wt_d  = wt_pipe[i-1];
    end

    // valid is reset, payload only moves with a valid packet
    always_ff @(posedge nvdla_core_clk) begin
      if (reset) begin
        dat_pipe[i].valid <= 1'b0;
      end else begin
        dat_pipe[i].valid <= dat_d.valid;
      end
      if (dat_d.valid) begin
        dat_pipe[i].pd   <= dat_d.pd;
        dat_pipe[i].data <= dat_d.data;
      end
    end

    always_ff @(posedge nvdla_core_clk) begin
      if (reset) begin
        wt_pipe[i].valid <= 1'b0;
      end else begin
        wt_pipe[i].valid <= wt_d.valid;
      end
      if (wt_d.valid) begin
        wt_pipe[i].kidx <= wt_d.kidx;
        wt_pipe[i].data <= wt_d.data;
      end
    end
  end

  assign dat_rt = dat_pipe[CMAC_IN_RT_LATENCY-1];
  assign wt_rt  = wt_pipe[CMAC_IN_RT_LATENCY-1];

endmodule

// File: rtl/cmac_mac_array.sv
// cmac MAC array
// weight shadow for ATOMK_HALF kernels and a two-stage pipeline, products
// in the first stage and an adder tree per kernel in the second
module cmac_mac_array
  import cmac_pkg::*;
(
  input  logic       nvdla_core_clk,
  input  logic       reset,
  input  cmac_mask_t kernel_en,
  input  cmac_dat_t  dat_rt,
  input  cmac_wt_t   wt_rt,
  output cmac_out_t  mac_out
);

  // one weight atom per kernel
  cmac_byte_t [CMAC_ATOMC-1:0] wt_shadow [CMAC_ATOMK_HALF];

  // stage 1 registers
  logic                        s1_valid;
  cmac_mask_t                  s1_mask;
  cmac_pd_t                    s1_pd;
  cmac_prod_t [CMAC_ATOMC-1:0] s1_prod [CMAC_ATOMK_HALF];

  // sign-extending multiply of two bytes
  function automatic cmac_prod_t mul_byte(input cmac_byte_t a, input cmac_byte_t b);
    cmac_prod_t a_ext;
    cmac_prod_t b_ext;
    a_ext = cmac_prod_t'(a);
    b_ext = cmac_prod_t'(b);
    return a_ext * b_ext;
  endfunction

  // binary adder tree, heap indexed with the leaves at the top
  function automatic cmac_result_t sum_atom(input cmac_prod_t [CMAC_ATOMC-1:0] p);
    cmac_result_t node [2*CMAC_ATOMC-1];
    for (int c = 0; c < CMAC_ATOMC; c++) begin
      node[CMAC_ATOMC-1+c] = cmac_result_t'(p[c]);
    end
    for (int n = CMAC_ATOMC - 2; n >= 0; n--) begin
      node[n] = node[2*n+1] + node[2*n+2];
    end
    return node[0];
  endfunction

  // ==========================================================================
  // weight shadow
  // ==========================================================================
  // a load at this edge is seen by packets entering stage 1 from the next edge
  always_ff @(posedge nvdla_core_clk) begin
    if (wt_rt.valid) begin
      wt_shadow[wt_rt.kidx] <= wt_rt.data;
    end
  end

  // ==========================================================================
  // stage 1: products
  // ==========================================================================
  always_ff @(posedge nvdla_core_clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
      s1_mask  <= '0;
    end else begin
      s1_valid <= dat_rt.valid;
      // kernel enable is sampled together with the packet
      s1_mask  <= kernel_en & {CMAC_ATOMK_HALF{dat_rt.valid}};
    end
    if (dat_rt.valid) begin
      s1_pd <= dat_rt.pd;
    end
  end

  // disabled kernels keep their old products
  for (genvar k = 0; k < CMAC_ATOMK_HALF; k++) begin : g_mul
    always_ff @(posedge nvdla_core_clk) begin
      if (dat_rt.valid && kernel_en[k]) begin
        for (int c = 0; c < CMAC_ATOMC; c++) begin
          s1_prod[k][c] <= mul_byte(dat_rt.data[c], wt_shadow[k][c]);
        end
      end
    end
  end

  // ==========================================================================
  // stage 2: adder tree
  // ==========================================================================
  always_ff @(posedge nvdla_core_clk) begin
    if (reset) begin
      mac_out.valid <= 1'b0;
      mac_out.mask  <= '0;
    end else begin
      mac_out.valid <= s1_valid;
      mac_out.mask  <= s1_mask;
    end
    if (s1_valid) begin
      mac_out.pd <= s1_pd;
    end
    // lanes outside the mask hold their last sum
    for (int k = 0; k < CMAC_ATOMK_HALF; k++) begin
      if (s1_mask[k]) begin
        mac_out.data[k] <= sum_atom(s1_prod[k]);
      end
    end
  end

endmodule

// File: rtl/cmac_out_rt.sv
// cmac output retiming
// delays valid, mask, stripe info and partial sums towards the accumulator
// and raises the layer-done pulse one cycle after the last output
module cmac_out_rt
  import cmac_pkg::*;
(
  input  logic      nvdla_core_clk,
  input  logic      reset,
  input  cmac_out_t mac_out,
  output cmac_out_t mac2accu,
  output logic      dp2reg_done
);

  cmac_out_t                    out_pipe [CMAC_OUT_RT_LATENCY];
  logic                         layer_done;
  logic [CMAC_OUT_RT_LATENCY:0] done_q;

  // ==========================================================================
  // data retiming
  // ==========================================================================
  for (genvar i = 0; i < CMAC_OUT_RT_LATENCY; i++) begin : g_stage
    cmac_out_t out_d;

    if (i == 0) begin : g_head
      assign out_d = mac_out;
    end else begin : g_body
      assign out_d = out_pipe[i-1];
    end

    always_ff @(posedge nvdla_core_clk) begin
      if (reset) begin
        out_pipe[i].valid <= 1'b0;
        out_pipe[i].mask  <= '0;
        out_pipe[i].pd    <= '0;
      end else begin
        out_pipe[i].valid <= out_d.valid;
        out_pipe[i].mask  <= out_d.mask;
        // stripe info holds between packets
        if (out_d.valid) begin
          out_pipe[i].pd <= out_d.pd;
        end
      end
      // result lanes carry no reset and load per mask bit
      for (int k = 0; k < CMAC_ATOMK_HALF; k++) begin
        if (out_d.mask[k]) begin
          out_pipe[i].data[k] <= out_d.data[k];
        end
      end
    end
  end

  assign mac2accu = out_pipe[CMAC_OUT_RT_LATENCY-1];

  // ==========================================================================
  // layer done
  // ==========================================================================
  // last packet of a layer closes both the stripe and the layer
  assign layer_done = mac_out.valid &
                      mac_out.pd[PKT_LAYER_END_FIELD] &
                      mac_out.pd[PKT_STRIPE_END_FIELD];

  // one stage longer than the data path
  always_ff @(posedge nvdla_core_clk) begin
    if (reset) begin
      done_q <= '0;
    end else begin
      done_q <= {done_q[CMAC_OUT_RT_LATENCY-1:0], layer_done};
    end
  end

  assign dp2reg_done = done_q[CMAC_OUT_RT_LATENCY];

endmodule

// File: rtl/cmac_core.sv
// cmac core
// convolution MAC core: APB configuration, input retiming, MAC array
// and output retiming towards the accumulator
module cmac_core
  import cmac_pkg::*;
(
  input  logic      nvdla_core_clk,
  input  logic      reset,
  input  apb_req_t  apb_req,
  output apb_rsp_t  apb_rsp,
  input  cmac_wt_t  wt_in,
  input  cmac_dat_t dat_in,
  output cmac_out_t mac2accu,
  output logic      dp2reg_done
);

  // configuration
  logic       op_en;
  cmac_mask_t kernel_en;

  // datapath between the stages
  cmac_dat_t  dat_rt;
  cmac_wt_t   wt_rt;
  cmac_out_t  mac_out;

  // ==========================================================================
  // registers
  // ==========================================================================
  cmac_cfg_regs u_cfg_regs (
    .nvdla_core_clk (nvdla_core_clk),
    .reset          (reset),
    .apb_req        (apb_req),
    .apb_rsp        (apb_rsp),
    .dp2reg_done    (dp2reg_done),
    .op_en          (op_en),
    .kernel_en      (kernel_en)
  );

  // ==========================================================================
  // datapath
  // ==========================================================================
  cmac_in_rt u_in_rt (
    .nvdla_core_clk (nvdla_core_clk),
    .reset          (reset),
    .op_en          (op_en),
    .dat_in         (dat_in),
    .wt_in          (wt_in),
    .dat_rt         (dat_rt),
    .wt_rt          (wt_rt)
  );

  cmac_mac_array u_mac_array (
    .nvdla_core_clk (nvdla_core_clk),
    .reset          (reset),
    .kernel_en      (kernel_en),
    .dat_rt         (dat_rt),
    .wt_rt          (wt_rt),
    .mac_out        (mac_out)
  );

  // also feeds layer done back to the registers
  cmac_out_rt u_out_rt (
    .nvdla_core_clk (nvdla_core_clk),
    .reset          (reset),
    .mac_out        (mac_out),
    .mac2accu       (mac2accu),
    .dp2reg_done    (dp2reg_done)
  );

endmodule

// File: sim/cmac_properties.sv
// cmac core properties
// bound into the core, watches layer-done timing against the output,
// the output valid under reset and the APB error response
module cmac_properties
  import cmac_pkg::*;
(
  input logic      nvdla_core_clk,
  input logic      reset,
  input apb_req_t  apb_req,
  input apb_rsp_t  apb_rsp,
  input cmac_out_t mac2accu,
  input logic      dp2reg_done
);

  // failures seen so far, read by the testbench at the end
  int   assert_fail_cnt = 0;
  logic last_out;

  // last output of a layer closes both the stripe and the layer
  assign last_out = mac2accu.valid &
                    mac2accu.pd[PKT_LAYER_END_FIELD] &
                    mac2accu.pd[PKT_STRIPE_END_FIELD];

  // ==========================================================================
  // output timing
  // ==========================================================================
  a_done_after_last: assert property (
    @(posedge nvdla_core_clk) disable iff (reset) last_out |=> dp2reg_done
  ) else begin
    assert_fail_cnt++;
    $error("layer done missing one cycle after the last output");
  end

  // no pulse without a last output just before it
  a_done_only_after_last: assert property (
    @(posedge nvdla_core_clk) disable iff (reset) dp2reg_done |-> $past(last_out)
  ) else begin
    assert_fail_cnt++;
    $error("layer done without a last output in the cycle before");
  end

  a_valid_in_reset: assert property (
    @(posedge nvdla_core_clk) reset |=> !mac2accu.valid
  ) else begin
    assert_fail_cnt++;
    $error("mac2accu valid high while in reset");
  end

  // ==========================================================================
  // APB
  // ==========================================================================
  // an access cycle is the one right after a setup cycle on the bus
  a_slverr_in_access: assert property (
    @(posedge nvdla_core_clk) disable iff (reset)
      apb_rsp.pslverr |-> apb_req.psel && apb_req.penable &&
                          $past(apb_req.psel && !apb_req.penable)
  ) else begin
    assert_fail_cnt++;
    $error("pslverr high outside an access cycle");
  end

endmodule

bind cmac_core cmac_properties u_properties (
  .nvdla_core_clk (nvdla_core_clk),
  .reset          (reset),
  .apb_req        (apb_req),
  .apb_rsp        (apb_rsp),
  .mac2accu       (mac2accu),
  .dp2reg_done    (dp2reg_done)
);

// File: sim/cmac_tb.sv
// cmac testbench
// configures the core over APB, loads weights, streams random activation
// packets and checks every partial sum against a dot-product model
module cmac_tb
  import cmac_pkg::*;
();

  localparam int CLK_HALF   = 20;
  localparam int WAIT_LIMIT = 100;
  localparam int RUN_LIMIT  = 5000;

  logic      nvdla_core_clk;
  logic      reset;
  apb_req_t  apb_req;
  apb_rsp_t  apb_rsp;
  cmac_wt_t  wt_in;
  cmac_dat_t dat_in;
  cmac_out_t mac2accu;
  logic      dp2reg_done;

  // model state, weights and kernel enable as the DUT should hold them
  cmac_byte_t [CMAC_ATOMC-1:0] wt_model [CMAC_ATOMK_HALF];
  cmac_mask_t                  kernel_model;
  cmac_out_t                   exp_q [$];
  logic [31:0]                 lcg_state;
  int                          value_errors;
  int                          other_errors;
  int                          assert_fails;
  int                          done_pulses;

  cmac_core u_dut (
    .nvdla_core_clk (nvdla_core_clk),
    .reset          (reset),
    .apb_req        (apb_req),
    .apb_rsp        (apb_rsp),
    .wt_in          (wt_in),
    .dat_in         (dat_in),
    .mac2accu       (mac2accu),
    .dp2reg_done    (dp2reg_done)
  );

  always #CLK_HALF nvdla_core_clk = ~nvdla_core_clk;

  // ==========================================================================
  // reference model
  // ==========================================================================
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // tag and stripe start random, stripe and layer end clear
  function automatic cmac_pd_t random_pd();
    logic [31:0] r;
    r = lcg_next();
    return {2'b00, r[22:16]};
  endfunction

  task automatic rand_atom(output cmac_byte_t [CMAC_ATOMC-1:0] atom);
    logic [31:0] r;
    for (int c = 0; c < CMAC_ATOMC; c++) begin
      r = lcg_next();
      atom[c] = r[31:24];
    end
  endtask

  // signed dot product of one activation atom with one weight atom
  function automatic cmac_result_t ref_dot(input cmac_byte_t [CMAC_ATOMC-1:0] act,
                                           input cmac_byte_t [CMAC_ATOMC-1:0] wt);
    int acc;
    acc = 0;
    for (int c = 0; c < CMAC_ATOMC; c++) begin
      acc += int'($signed(act[c])) * int'($signed(wt[c]));
    end
    return cmac_result_t'(acc);
  endfunction

  // ==========================================================================
  // compare tasks
  // ==========================================================================
  task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want) begin
      value_errors++;
      $display("error at %0t: %s got %b expected %b", $time, name, got, want);
    end
  endtask

  task automatic check_mask(input string name, input cmac_mask_t got, input cmac_mask_t want);
    if (got !== want) begin
      value_errors++;
      $display("error at %0t: %s got %b expected %b", $time, name, got, want);
    end
  endtask

  task automatic check_pd(input string name, input cmac_pd_t got, input cmac_pd_t want);
    if (got !== want) begin
      value_errors++;
      $display("error at %0t: %s got %h expected %h", $time, name, got, want);
    end
  endtask

  task automatic check_result(input string name, input cmac_result_t got,
                              input cmac_result_t want);
    if (got !== want) begin
      value_errors++;
      $display("error at %0t: %s got %0d expected %0d", $time, name, got, want);
    end
  endtask

  task automatic check_apb(input string name, input apb_data_t got, input apb_data_t want);
    if (got !== want) begin
      value_errors++;
      $display("error at %0t: %s got %h expected %h", $time, name, got, want);
    end
  endtask

  // ==========================================================================
  // APB master
  // ==========================================================================
  // response sampled mid low phase, before the edge that ends the access
  task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
    int n;
    @(negedge nvdla_core_clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge nvdla_core_clk);
    apb_req.penable = 1'b1;
    #(CLK_HALF / 2);
    n = 0;
    while (!apb_rsp.pready && n < WAIT_LIMIT) begin
      n++;
      @(negedge nvdla_core_clk);
      #(CLK_HALF / 2);
    end
    if (!apb_rsp.pready) begin
      other_errors++;
      $display("apb access to %03h never saw pready", addr);
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(negedge nvdla_core_clk);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata, input logic want_err);
    apb_data_t rdata;
    logic      err;
    apb_access(1'b1, addr, wdata, rdata, err);
    check_bit("apb_rsp.pslverr", err, want_err);
    if (addr == REG_KERNEL_EN_ADDR) begin
      kernel_model = wdata[CMAC_ATOMK_HALF-1:0];
    end
  endtask

  task automatic apb_read(input apb_addr_t addr, input apb_data_t want, input logic want_err);
    apb_data_t rdata;
    logic      err;
    apb_access(1'b0, addr, '0, rdata, err);
    check_apb($sformatf("apb_rsp.prdata at %03h", addr), rdata, want);
    check_bit("apb_rsp.pslverr", err, want_err);
  endtask

  // ==========================================================================
  // datapath stimulus
  // ==========================================================================
  task automatic load_weight(input cmac_kidx_t kidx);
    cmac_byte_t [CMAC_ATOMC-1:0] atom;
    rand_atom(atom);
    @(negedge nvdla_core_clk);
    dat_in.valid   = 1'b0;
    wt_in.valid    = 1'b1;
    wt_in.kidx     = kidx;
    wt_in.data     = atom;
    wt_model[kidx] = atom;
  endtask

  // expected output uses weights and mask in effect when the packet is sent
  task automatic drive_packet(input cmac_pd_t pd, input bit expect_out);
    cmac_byte_t [CMAC_ATOMC-1:0] atom;
    cmac_out_t                   want;
    rand_atom(atom);
    want.valid = 1'b1;
    want.mask  = kernel_model;
    want.pd    = pd;
    for (int k = 0; k < CMAC_ATOMK_HALF; k++) begin
      want.data[k] = kernel_model[k] ? ref_dot(atom, wt_model[k]) : '0;
    end
    @(negedge nvdla_core_clk);
    wt_in.valid  = 1'b0;
    dat_in.valid = 1'b1;
    dat_in.pd    = pd;
    dat_in.data  = atom;
    if (expect_out) begin
      exp_q.push_back(want);
    end
  endtask

  task automatic drive_idle(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge nvdla_core_clk);
      dat_in.valid = 1'b0;
      wt_in.valid  = 1'b0;
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
      n++;
      @(negedge nvdla_core_clk);
    end
    if (exp_q.size() != 0) begin
      other_errors++;
      $display("missing output: %0d packets never reached mac2accu", exp_q.size());
      exp_q.delete();
    end
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    while (!dp2reg_done && n < WAIT_LIMIT) begin
      n++;
      @(negedge nvdla_core_clk);
    end
    if (!dp2reg_done) begin
      other_errors++;
      $display("layer done pulse never came after the last packet of the layer");
    end
  endtask

  // ==========================================================================
  // output comparison
  // ==========================================================================
  always @(negedge nvdla_core_clk) begin : compare_outputs
    cmac_out_t want;
    if (!reset && mac2accu.valid) begin
      if (exp_q.size() == 0) begin
        other_errors++;
        $display("unexpected output at %0t with no packet outstanding", $time);
      end else begin
        want = exp_q.pop_front();
        check_mask("mac2accu.mask", mac2accu.mask, want.mask);
        check_pd("mac2accu.pd", mac2accu.pd, want.pd);
        // lanes outside the mask hold old sums
        for (int k = 0; k < CMAC_ATOMK_HALF; k++) begin
          if (want.mask[k]) begin
            check_result($sformatf("mac2accu.data[%0d]", k), mac2accu.data[k], want.data[k]);
          end
        end
      end
    end
  end

  always @(negedge nvdla_core_clk) begin
    if (!reset && dp2reg_done) begin
      done_pulses++;
    end
  end

  // ==========================================================================
  // test sequence
  // ==========================================================================
  initial begin
    nvdla_core_clk = 1'b0;
    reset          = 1'b1;
    apb_req        = '0;
    wt_in          = '0;
    dat_in         = '0;
    lcg_state      = 32'h86e1_c89a;
    kernel_model   = '0;
    value_errors   = 0;
    other_errors   = 0;
    assert_fails   = 0;
    done_pulses    = 0;
    for (int k = 0; k < CMAC_ATOMK_HALF; k++) begin
      wt_model[k] = '0;
    end
    repeat (5) @(posedge nvdla_core_clk);
    @(negedge nvdla_core_clk);
    reset = 1'b0;

    // reset state
    check_bit("mac2accu.valid", mac2accu.valid, 1'b0);
    check_mask("mac2accu.mask", mac2accu.mask, '0);
    check_bit("dp2reg_done", dp2reg_done, 1'b0);
    apb_read(REG_OP_EN_ADDR, '0, 1'b0);
    apb_read(REG_KERNEL_EN_ADDR, '0, 1'b0);
    apb_read(REG_DONE_CNT_ADDR, '0, 1'b0);

    // all kernels, back-to-back random packets
    apb_write(REG_KERNEL_EN_ADDR, 32'h0000_000f, 1'b0);
    apb_write(REG_OP_EN_ADDR, 32'h0000_0001, 1'b0);
    for (int k = 0; k < CMAC_ATOMK_HALF; k++) begin
      load_weight(cmac_kidx_t'(k));
    end
    for (int i = 0; i < 24; i++) begin
      drive_packet(random_pd(), 1'b1);
    end
    drive_idle(1);
    wait_drain();

    // partial mask, kernel 2 reloaded with packets still in flight
    apb_write(REG_KERNEL_EN_ADDR, 32'h0000_0005, 1'b0);
    apb_read(REG_KERNEL_EN_ADDR, 32'h0000_0005, 1'b0);
    for (int i = 0; i < 5; i++) begin
      drive_packet(random_pd(), 1'b1);
    end
    load_weight(cmac_kidx_t'(2));
    for (int i = 0; i < 5; i++) begin
      drive_packet(random_pd(), 1'b1);
    end
    drive_idle(1);
    wait_drain();

    // last packet of the layer ends both the stripe and the layer
    drive_packet(random_pd(), 1'b1);
    drive_packet(random_pd(), 1'b1);
    drive_packet({1'b1, 1'b1, 1'b0, 6'h2a}, 1'b1);
    drive_idle(1);
    wait_done();
    wait_drain();
    apb_read(REG_OP_EN_ADDR, '0, 1'b0);
    apb_read(REG_DONE_CNT_ADDR, 32'h0000_0001, 1'b0);

    // op enable is off, these are dropped at the input
    for (int i = 0; i < 4; i++) begin
      drive_packet(random_pd(), 1'b0);
    end
    drive_idle(12);
    if (done_pulses != 1) begin
      other_errors++;
      $display("expected one layer done pulse but saw %0d", done_pulses);
    end

    // unmapped addresses and the read-only counter
    apb_read(12'h00c, '0, 1'b1);
    apb_write(12'h010, 32'h0000_0001, 1'b1);
    apb_write(REG_DONE_CNT_ADDR, 32'h0000_0055, 1'b0);
    apb_read(REG_DONE_CNT_ADDR, 32'h0000_0001, 1'b0);
    drive_idle(2);

    assert_fails = u_dut.u_properties.assert_fail_cnt;
    $display("value errors: %0d, other errors: %0d, assertion failures: %0d",
             value_errors, other_errors, assert_fails);
    if (value_errors == 0 && other_errors == 0 && assert_fails == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // hang guard for the whole run
  initial begin
    repeat (RUN_LIMIT) @(posedge nvdla_core_clk);
    $display("timeout: the test sequence did not finish within %0d cycles", RUN_LIMIT);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: project.f
rtl/cmac_pkg.sv
rtl/cmac_cfg_regs.sv
rtl/cmac_in_rt.sv
rtl/cmac_mac_array.sv
rtl/cmac_out_rt.sv
rtl/cmac_core.sv
sim/cmac_properties.sv
sim/cmac_tb.sv

// File: Makefile
# convolution MAC core, Verilator lint and simulation
TOP := cmac_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

# the run passes only when the log holds the pass line
sim:
	verilator --binary --assert -j 0 -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -qx "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log
